//--- ppu_asserts.sv
// Tile fetcher stream checks
`timescale 1ns/1ps
`default_nettype none

module ppu_asserts
	import ppu_pkg::*;
(
	input wire logic     clk,
	input wire logic     rst,
	input wire logic     coord_valid,
	input wire logic     coord_ready,
	input wire coord_t   screen_x,
	input wire coord_t   screen_y,
	input wire coord_t   world_x,
	input wire coord_t   world_y,
	input wire logic     vram_rd,
	input wire logic     pix_valid,
	input wire logic     pix_ready,
	input wire coord_t   pix_x,
	input wire coord_t   pix_y,
	input wire pal_idx_t pix_idx
);

	// Stalled coordinate holds
	coord_hold: assert property (@(posedge clk) disable iff (!rst)
		coord_valid && !coord_ready |=>
			coord_valid && $stable({screen_x, screen_y, world_x, world_y}))
		else $error("coordinate changed while stalled");

	// Stalled pixel holds
	pix_hold: assert property (@(posedge clk) disable iff (!rst)
		pix_valid && !pix_ready |=> pix_valid && $stable({pix_x, pix_y, pix_idx}))
		else $error("pixel changed while stalled");

	// Only one read in flight
	one_read: assert property (@(posedge clk) disable iff (!rst)
		vram_rd |=> !vram_rd)
		else $error("read issued while data outstanding");

	// Still quiet on the first clocked edge out of reset
	reset_quiet: assert property (@(posedge clk) !rst ##1 rst |=> !pix_valid)
		else $error("pix_valid high coming out of reset");

endmodule

bind ppu_tile_fetch ppu_asserts u_asserts (
	.clk         (clk),
	.rst         (rst),
	.coord_valid (coord_valid),
	.coord_ready (coord_ready),
	.screen_x    (screen_x),
	.screen_y    (screen_y),
	.world_x     (world_x),
	.world_y     (world_y),
	.vram_rd     (vram_rd),
	.pix_valid   (pix_valid),
	.pix_ready   (pix_ready),
	.pix_x       (pix_x),
	.pix_y       (pix_y),
	.pix_idx     (pix_idx)
);

`default_nettype wire

//--- ppu_frame_seq.sv
// Raster frame sequencer
`timescale 1ns/1ps
`default_nettype none

module ppu_frame_seq
	import ppu_pkg::*;
#(
	parameter int unsigned screen_w      = 256,
	parameter int unsigned screen_h      = 240,
	parameter int unsigned vblank_cycles = 64
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ctrl_enable,
	input  wire coord_t scroll_x,
	input  wire coord_t scroll_y,
	output logic        frame_start,
	output logic        frame_end,
	output logic        coord_valid,
	input  wire logic   coord_ready,
	output coord_t      screen_x,
	output coord_t      screen_y,
	output coord_t      world_x,
	output coord_t      world_y
);

	localparam int cnt_w = $clog2(vblank_cycles + 1);
	localparam coord_t last_x = coord_t'(screen_w - 1);
	localparam coord_t last_y = coord_t'(screen_h - 1);

	// st_frame sits between lines, st_line issues coordinates
	typedef enum logic [1:0] {
		st_idle,
		st_frame,
		st_line,
		st_blank
	} seq_state_t;

	seq_state_t       state;
	coord_t           x_cnt;
	coord_t           y_cnt;
	coord_t           sx_lat;
	coord_t           sy_lat;
	logic [cnt_w-1:0] blank_cnt;
	logic             accept;

	assign accept = coord_valid && coord_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state       <= st_idle;
			x_cnt       <= '0;
			y_cnt       <= '0;
			sx_lat      <= '0;
			sy_lat      <= '0;
			blank_cnt   <= '0;
			coord_valid <= 1'b0;
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
		end else begin
			// Single cycle pulses
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
			case (state)
				st_idle: begin
					if (ctrl_enable) begin
						frame_start <= 1'b1;
						sy_lat      <= scroll_y;
						y_cnt       <= '0;
						state       <= st_frame;
					end
				end
				st_frame: begin
					// Horizontal scroll taken with first coordinate of the line
					sx_lat      <= scroll_x;
					x_cnt       <= '0;
					coord_valid <= 1'b1;
					state       <= st_line;
				end
				st_line: begin
					if (accept) begin
						if (x_cnt != last_x) begin
							x_cnt <= x_cnt + 8'd1;
						end else if (y_cnt != last_y) begin
							coord_valid <= 1'b0;
							y_cnt       <= y_cnt + 8'd1;
							state       <= st_frame;
						end else begin
							// Last pixel of the frame
							coord_valid <= 1'b0;
							frame_end   <= 1'b1;
							blank_cnt   <= '0;
							state       <= st_blank;
						end
					end
				end
				default: begin
					// Blanking wait before enable is checked again
					if (blank_cnt == cnt_w'(vblank_cycles - 1)) begin
						state <= st_idle;
					end else begin
						blank_cnt <= blank_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// World position wraps on the 256x256 map
	assign screen_x = x_cnt;
	assign screen_y = y_cnt;
	assign world_x  = x_cnt + sx_lat;
	assign world_y  = y_cnt + sy_lat;

endmodule

`default_nettype wire

//--- ppu_pkg.sv
// Tile renderer shared definitions
`default_nettype none

package ppu_pkg;

	// Video memory address
	typedef logic [15:0] vram_addr_t;

	// Pixel coordinate, screen or 256x256 world map
	typedef logic [7:0] coord_t;

	// Palette index
	// High two bits from attribute, low two from pattern planes
	typedef logic [3:0] pal_idx_t;

	// CPU register selector
	typedef enum logic [1:0] {
		reg_ctrl     = 2'd0,
		reg_scroll_x = 2'd1,
		reg_scroll_y = 2'd2,
		reg_status   = 2'd3
	} reg_sel_t;

	// Render enable in the control byte
	localparam int ctrl_enable_bit = 0;

	// Vertical blank flag in the status byte
	localparam int status_vblank_bit = 7;

	// Memory map
	// Nametable is 32x32 tiles, row*32 + col
	localparam vram_addr_t name_base = 16'h0000;
	// One attribute byte per 4x4 tile block, block_row*8 + block_col
	localparam vram_addr_t attr_base = 16'h0400;
	// 16 bytes per pattern, plane 1 eight bytes after plane 0
	localparam vram_addr_t pattern_base = 16'h1000;

endpackage

`default_nettype wire

//--- ppu_regs.sv
// CPU register block
`timescale 1ns/1ps
`default_nettype none

module ppu_regs
	import ppu_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       cpu_wr,
	input  wire logic       cpu_rd,
	input  wire reg_sel_t   cpu_sel,
	input  wire logic [7:0] cpu_wdata,
	output logic      [7:0] cpu_rdata,
	input  wire logic       frame_end,
	input  wire logic       frame_start,
	output logic            ctrl_enable,
	output coord_t          scroll_x,
	output coord_t          scroll_y
);

	logic [7:0] ctrl_reg;
	logic       vblank_flag;
	logic [7:0] status_byte;
	logic       status_read;

	// Status read clears the flag after returning it
	assign status_read = cpu_rd && (cpu_sel == reg_status);

	always_comb begin
		status_byte = '0;
		status_byte[status_vblank_bit] = vblank_flag;
	end

	// Control and scroll bytes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ctrl_reg <= '0;
			scroll_x <= '0;
			scroll_y <= '0;
		end else if (cpu_wr) begin
			case (cpu_sel)
				reg_ctrl:     ctrl_reg <= cpu_wdata;
				reg_scroll_x: scroll_x <= cpu_wdata;
				reg_scroll_y: scroll_y <= cpu_wdata;
				// Status is read only
				default:      ;
			endcase
		end
	end

	// Vertical blank flag
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vblank_flag <= 1'b0;
		end else if (frame_end) begin
			// Set beats a clear in the same cycle
			vblank_flag <= 1'b1;
		end else if (status_read || frame_start) begin
			vblank_flag <= 1'b0;
		end
	end

	// Read data, valid the cycle after cpu_rd
	always_ff @(posedge clk) begin
		if (cpu_rd) begin
			case (cpu_sel)
				reg_ctrl:     cpu_rdata <= ctrl_reg;
				reg_scroll_x: cpu_rdata <= scroll_x;
				reg_scroll_y: cpu_rdata <= scroll_y;
				default:      cpu_rdata <= status_byte;
			endcase
		end
	end

	assign ctrl_enable = ctrl_reg[ctrl_enable_bit];

endmodule

`default_nettype wire

//--- ppu_tile_fetch.sv
// Background tile fetcher
`timescale 1ns/1ps
`default_nettype none

module ppu_tile_fetch
	import ppu_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       coord_valid,
	output logic            coord_ready,
	input  wire coord_t     screen_x,
	input  wire coord_t     screen_y,
	input  wire coord_t     world_x,
	input  wire coord_t     world_y,
	output logic            vram_rd,
	output vram_addr_t      vram_addr,
	input  wire logic [7:0] vram_data,
	output logic            pix_valid,
	input  wire logic       pix_ready,
	output coord_t          pix_x,
	output coord_t          pix_y,
	output pal_idx_t        pix_idx
);

	// One state per memory read
	typedef enum logic [2:0] {
		st_idle,
		st_name,
		st_attr,
		st_pat0,
		st_pat1
	} fetch_state_t;

	fetch_state_t state;
	logic         tag_valid;
	coord_t       cur_sx;
	coord_t       cur_sy;
	coord_t       cur_wx;
	coord_t       cur_wy;
	logic [7:0]   tile_num;
	logic [1:0]   attr_field;
	logic [7:0]   plane0;
	logic [7:0]   plane1;
	logic         accept;
	logic         hit;
	logic         data_phase;
	logic [1:0]   attr_quad;
	logic [2:0]   bit_sel;
	vram_addr_t   name_addr;
	vram_addr_t   attr_addr;

	// Next coordinate only when idle and the output slot frees up
	assign coord_ready = (state == st_idle) && (!pix_valid || pix_ready);
	assign accept      = coord_valid && coord_ready;

	// Held tile tag is the coarse column and row of the latched world position
	assign hit = tag_valid && (world_x[7:3] == cur_wx[7:3]) && (world_y == cur_wy);

	// Read data arrives in the cycle after vram_rd
	assign data_phase = (state != st_idle) && !vram_rd;

	assign name_addr = name_base + vram_addr_t'({world_y[7:3], world_x[7:3]});
	assign attr_addr = attr_base + vram_addr_t'({cur_wy[7:5], cur_wx[7:5]});
	// Quadrant order TL, TR, BL, BR from the low bits up
	assign attr_quad = {cur_wy[4], cur_wx[4]};

	// FSM, read strobe and output valid
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= st_idle;
			vram_rd   <= 1'b0;
			pix_valid <= 1'b0;
			tag_valid <= 1'b0;
		end else begin
			if (pix_valid && pix_ready) begin
				pix_valid <= 1'b0;
			end
			if (accept) begin
				tag_valid <= 1'b1;
				if (hit) begin
					pix_valid <= 1'b1;
				end else begin
					vram_rd <= 1'b1;
					state   <= st_name;
				end
			end else if (state != st_idle) begin
				if (vram_rd) begin
					vram_rd <= 1'b0;
				end else begin
					case (state)
						st_name: state <= st_attr;
						st_attr: state <= st_pat0;
						st_pat0: state <= st_pat1;
						default: state <= st_idle;
					endcase
					vram_rd   <= (state != st_pat1);
					pix_valid <= (state == st_pat1);
				end
			end
		end
	end

	// Latched coordinates, tile data and read address
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_sx    <= screen_x;
			cur_sy    <= screen_y;
			cur_wx    <= world_x;
			cur_wy    <= world_y;
			vram_addr <= name_addr;
		end else if (data_phase) begin
			case (state)
				st_name: begin
					tile_num  <= vram_data;
					vram_addr <= attr_addr;
				end
				st_attr: begin
					attr_field <= vram_data[{attr_quad, 1'b0} +: 2];
					vram_addr  <= pattern_base + vram_addr_t'({tile_num, 1'b0, cur_wy[2:0]});
				end
				st_pat0: begin
					plane0    <= vram_data;
					vram_addr <= pattern_base + vram_addr_t'({tile_num, 1'b1, cur_wy[2:0]});
				end
				default: plane1 <= vram_data;
			endcase
		end
	end

	// Bit 7 is the leftmost pixel
	assign bit_sel = ~cur_wx[2:0];
	assign pix_x   = cur_sx;
	assign pix_y   = cur_sy;
	assign pix_idx = {attr_field, plane1[bit_sel], plane0[bit_sel]};

endmodule

`default_nettype wire

//--- ppu_top.sv
// Tile renderer top level
`timescale 1ns/1ps
`default_nettype none

module ppu_top
	import ppu_pkg::*;
#(
	parameter int unsigned screen_w      = 256,
	parameter int unsigned screen_h      = 240,
	parameter int unsigned vblank_cycles = 64
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       cpu_wr,
	input  wire logic       cpu_rd,
	input  wire reg_sel_t   cpu_sel,
	input  wire logic [7:0] cpu_wdata,
	output logic      [7:0] cpu_rdata,
	output logic            vram_rd,
	output vram_addr_t      vram_addr,
	input  wire logic [7:0] vram_data,
	output logic            pix_valid,
	input  wire logic       pix_ready,
	output coord_t          pix_x,
	output coord_t          pix_y,
	output pal_idx_t        pix_idx
);

	// Register block to sequencer
	logic   ctrl_enable;
	coord_t scroll_x;
	coord_t scroll_y;
	logic   frame_start;
	logic   frame_end;

	// Coordinate stream
	logic   coord_valid;
	logic   coord_ready;
	coord_t screen_x;
	coord_t screen_y;
	coord_t world_x;
	coord_t world_y;

	ppu_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.cpu_wr      (cpu_wr),
		.cpu_rd      (cpu_rd),
		.cpu_sel     (cpu_sel),
		.cpu_wdata   (cpu_wdata),
		.cpu_rdata   (cpu_rdata),
		.frame_end   (frame_end),
		.frame_start (frame_start),
		.ctrl_enable (ctrl_enable),
		.scroll_x    (scroll_x),
		.scroll_y    (scroll_y)
	);

	ppu_frame_seq #(
		.screen_w      (screen_w),
		.screen_h      (screen_h),
		.vblank_cycles (vblank_cycles)
	) u_frame_seq (
		.clk         (clk),
		.rst         (rst),
		.ctrl_enable (ctrl_enable),
		.scroll_x    (scroll_x),
		.scroll_y    (scroll_y),
		.frame_start (frame_start),
		.frame_end   (frame_end),
		.coord_valid (coord_valid),
		.coord_ready (coord_ready),
		.screen_x    (screen_x),
		.screen_y    (screen_y),
		.world_x     (world_x),
		.world_y     (world_y)
	);

	ppu_tile_fetch u_tile_fetch (
		.clk         (clk),
		.rst         (rst),
		.coord_valid (coord_valid),
		.coord_ready (coord_ready),
		.screen_x    (screen_x),
		.screen_y    (screen_y),
		.world_x     (world_x),
		.world_y     (world_y),
		.vram_rd     (vram_rd),
		.vram_addr   (vram_addr),
		.vram_data   (vram_data),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.pix_idx     (pix_idx)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the tile renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module tb_ppu \
	-f verilog.f -Mdir "$build_dir" -o sim_ppu
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$build_dir/sim_ppu" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "sim failed" "$log_file"; then
	exit 1
fi
exit 0

//--- tb_ppu.sv
// Tile renderer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ppu
	import ppu_pkg::*;
();

	// Small screen keeps a frame short
	localparam int screen_w      = 32;
	localparam int screen_h      = 16;
	localparam int vblank_cycles = 16;
	localparam int npix          = screen_w * screen_h;
	// Worst case per pixel is a miss plus back-pressure
	localparam int pix_cycles    = 12;
	localparam int num_frames    = 5;
	localparam int frame_limit   = npix * pix_cycles + 200;
	localparam longint watchdog_ns = longint'(num_frames * npix * pix_cycles + 4000) * 8;

	logic       clk = 1'b0;
	// Falls at time zero so the asynchronous reset fires
	logic       rst = 1'b1;
	logic       cpu_wr;
	logic       cpu_rd;
	reg_sel_t   cpu_sel;
	logic [7:0] cpu_wdata;
	logic [7:0] cpu_rdata;
	logic       vram_rd;
	vram_addr_t vram_addr;
	logic [7:0] vram_data = 8'h00;
	logic       pix_valid;
	logic       pix_ready = 1'b0;
	coord_t     pix_x;
	coord_t     pix_y;
	pal_idx_t   pix_idx;

	// 8 KB video memory image
	logic [7:0]  mem [0:8191];
	logic [31:0] rng_state    = 32'h4147cabf;
	// Separate stream for the ready pattern
	logic [31:0] ready_state  = ~32'h4147cabf;
	logic        ready_random = 1'b0;

	// Every accepted pixel, in arrival order
	coord_t   got_x_q[$];
	coord_t   got_y_q[$];
	pal_idx_t got_idx_q[$];
	pal_idx_t saved_idx_q[$];

	int err_count   = 0;
	int check_count = 0;
	int test_count  = 0;

	always #4 clk = ~clk;

	ppu_top #(
		.screen_w      (screen_w),
		.screen_h      (screen_h),
		.vblank_cycles (vblank_cycles)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.cpu_wr    (cpu_wr),
		.cpu_rd    (cpu_rd),
		.cpu_sel   (cpu_sel),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix_x     (pix_x),
		.pix_y     (pix_y),
		.pix_idx   (pix_idx)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng_state = lcg_step(rng_state);
		return rng_state[23:16];
	endfunction

	function automatic logic [7:0] mem_at(input int addr);
		return mem[addr[12:0]];
	endfunction

	// Expected palette index from the memory map rules
	function automatic pal_idx_t ref_pixel(input coord_t sx, input coord_t sy,
			input coord_t scx, input coord_t scy);
		coord_t     wx;
		coord_t     wy;
		logic [7:0] tile;
		logic [7:0] attr;
		logic [7:0] p0;
		logic [7:0] p1;
		logic [1:0] field;
		logic       bottom;
		logic       right;
		logic [2:0] col;
		int         pat;
		// World position wraps at 256
		wx = sx + scx;
		wy = sy + scy;
		tile = mem_at(int'(name_base) + 32 * (int'(wy) / 8) + int'(wx) / 8);
		attr = mem_at(int'(attr_base) + 8 * (int'(wy) / 32) + int'(wx) / 32);
		// Quadrant of the 32x32 pixel attribute block
		bottom = (int'(wy) % 32) >= 16;
		right  = (int'(wx) % 32) >= 16;
		if (!bottom && !right) begin
			field = attr[1:0];
		end else if (!bottom) begin
			field = attr[3:2];
		end else if (!right) begin
			field = attr[5:4];
		end else begin
			field = attr[7:6];
		end
		pat = int'(pattern_base) + 16 * int'(tile) + int'(wy) % 8;
		p0  = mem_at(pat);
		p1  = mem_at(pat + 8);
		// Leftmost pixel sits in bit 7
		col = 3'(7 - int'(wx) % 8);
		return {field, p1[col], p0[col]};
	endfunction

	// Memory answers in the cycle after the read strobe
	always @(negedge clk) begin
		if (vram_rd) begin
			vram_data = mem[vram_addr[12:0]];
		end
	end

	// Ready pattern, then capture what the next rising edge accepts
	always @(negedge clk) begin
		ready_state = lcg_step(ready_state);
		pix_ready   = ready_random ? ready_state[20] : 1'b1;
		if (rst && pix_valid && pix_ready) begin
			got_x_q.push_back(pix_x);
			got_y_q.push_back(pix_y);
			got_idx_q.push_back(pix_idx);
		end
	end

	task automatic write_reg(input reg_sel_t sel, input logic [7:0] data);
		@(negedge clk);
		cpu_wr    = 1'b1;
		cpu_sel   = sel;
		cpu_wdata = data;
		@(negedge clk);
		cpu_wr = 1'b0;
	endtask

	// Data is registered, sampled a cycle later
	task automatic read_reg(input reg_sel_t sel, output logic [7:0] data);
		@(negedge clk);
		cpu_rd  = 1'b1;
		cpu_sel = sel;
		@(negedge clk);
		cpu_rd = 1'b0;
		data   = cpu_rdata;
	endtask

	task automatic check_reg(input logic [7:0] got, input logic [7:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pixel(input coord_t got_x, input coord_t got_y, input pal_idx_t got_idx,
			input coord_t exp_x, input coord_t exp_y, input pal_idx_t exp_idx);
		check_count++;
		if (got_x !== exp_x || got_y !== exp_y || got_idx !== exp_idx) begin
			err_count++;
			$display("FAILED %0t: pixel (%0d,%0d) index %h, expected (%0d,%0d) index %h",
				$time, got_x, got_y, got_idx, exp_x, exp_y, exp_idx);
		end
	endtask

	task automatic wait_pixels(input int total);
		int cycles;
		cycles = 0;
		while (got_idx_q.size() < total && cycles < frame_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (got_idx_q.size() < total) begin
			err_count++;
			$display("Timeout: only %0d of %0d pixels arrived", got_idx_q.size(), total);
		end
	endtask

	// Raster order, each pixel against the reference
	task automatic check_frame(input int base, input coord_t scx, input coord_t scy);
		coord_t ex;
		coord_t ey;
		for (int i = 0; i < npix; i++) begin
			ex = coord_t'(i % screen_w);
			ey = coord_t'(i / screen_w);
			if (base + i < got_idx_q.size()) begin
				check_pixel(got_x_q[base + i], got_y_q[base + i], got_idx_q[base + i],
					ex, ey, ref_pixel(ex, ey, scx, scy));
			end
		end
	endtask

	// No pixel may follow the end of the frame
	task automatic settle(input int base, input int cycles);
		repeat (cycles) @(posedge clk);
		if (got_idx_q.size() != base + npix) begin
			err_count++;
			$display("Pixel count wrong: %0d arrived, %0d expected",
				got_idx_q.size() - base, npix);
		end
	endtask

	task automatic run_frame(input coord_t scx, input coord_t scy, output int base);
		write_reg(reg_scroll_x, scx);
		write_reg(reg_scroll_y, scy);
		base = got_idx_q.size();
		// Short enable pulse, exactly one frame
		write_reg(reg_ctrl, 8'h01);
		write_reg(reg_ctrl, 8'h00);
		wait_pixels(base + npix);
		check_frame(base, scx, scy);
		settle(base, 2 * vblank_cycles);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			$display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
		end
	endtask

	initial begin
		logic [7:0] val;
		logic [7:0] rd;
		coord_t     scx;
		coord_t     scy;
		int         base;
		int         errs;
		rst       = 1'b0;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		cpu_sel   = reg_ctrl;
		cpu_wdata = 8'h00;
		for (int a = 0; a < 8192; a++) begin
			mem[a[12:0]] = rand_byte();
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Register readback, enable bit kept clear
		errs = err_count;
		read_reg(reg_status, rd);
		check_reg(rd, 8'h00, "status after reset");
		for (int n = 0; n < 8; n++) begin
			val = rand_byte() & 8'hfe;
			scx = rand_byte();
			scy = rand_byte();
			write_reg(reg_ctrl, val);
			write_reg(reg_scroll_x, scx);
			write_reg(reg_scroll_y, scy);
			read_reg(reg_ctrl, rd);
			check_reg(rd, val, "ctrl");
			read_reg(reg_scroll_x, rd);
			check_reg(rd, scx, "scroll_x");
			read_reg(reg_scroll_y, rd);
			check_reg(rd, scy, "scroll_y");
		end
		// Status ignores writes
		write_reg(reg_status, 8'hff);
		read_reg(reg_status, rd);
		check_reg(rd, 8'h00, "status after write");
		write_reg(reg_ctrl, 8'h00);
		report_test("register readback", errs);

		errs = err_count;
		run_frame(8'h00, 8'h00, base);
		report_test("zero scroll frame", errs);

		// Scroll near the map edge so both axes wrap, fine bits non-zero
		errs = err_count;
		val = rand_byte();
		scx = {3'b111, val[4:0]};
		if (scx[2:0] == 3'd0) begin
			scx[0] = 1'b1;
		end
		val = rand_byte();
		scy = {4'b1111, val[3:0]};
		if (scy[2:0] == 3'd0) begin
			scy[0] = 1'b1;
		end
		run_frame(scx, scy, base);
		for (int i = 0; i < npix && base + i < got_idx_q.size(); i++) begin
			saved_idx_q.push_back(got_idx_q[base + i]);
		end
		report_test("scrolled frame", errs);

		// Same frame under random back-pressure
		errs = err_count;
		ready_random = 1'b1;
		run_frame(scx, scy, base);
		for (int i = 0; i < npix && i < saved_idx_q.size(); i++) begin
			if (base + i < got_idx_q.size()) begin
				check_pixel(got_x_q[base + i], got_y_q[base + i], got_idx_q[base + i],
					coord_t'(i % screen_w), coord_t'(i / screen_w), saved_idx_q[i]);
			end
		end
		report_test("back-pressure frame", errs);

		// Vertical blank flag, scroll_y write mid-frame
		errs = err_count;
		scx = rand_byte();
		scy = rand_byte();
		write_reg(reg_scroll_x, scx);
		write_reg(reg_scroll_y, scy);
		base = got_idx_q.size();
		write_reg(reg_ctrl, 8'h01);
		write_reg(reg_ctrl, 8'h00);
		wait_pixels(base + npix / 2);
		// Cleared at frame start
		read_reg(reg_status, rd);
		check_reg(rd, 8'h00, "status mid-frame");
		write_reg(reg_scroll_y, rand_byte());
		wait_pixels(base + npix);
		// Vertical blank is bit 7
		read_reg(reg_status, rd);
		check_reg(rd, 8'h80, "status after frame");
		read_reg(reg_status, rd);
		check_reg(rd, 8'h00, "status second read");
		check_frame(base, scx, scy);
		settle(base, 2 * vblank_cycles);
		report_test("vertical blank", errs);

		// Enable dropped mid-frame, frame still completes
		errs = err_count;
		scx = rand_byte();
		scy = rand_byte();
		write_reg(reg_scroll_x, scx);
		write_reg(reg_scroll_y, scy);
		base = got_idx_q.size();
		write_reg(reg_ctrl, 8'h01);
		wait_pixels(base + npix / 4);
		write_reg(reg_ctrl, 8'h00);
		wait_pixels(base + npix);
		check_frame(base, scx, scy);
		settle(base, 4 * vblank_cycles + 20);
		report_test("disable mid-frame", errs);

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Ends a stuck run
	initial begin
		#(watchdog_ns);
		$display("Watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
ppu_pkg.sv
ppu_regs.sv
ppu_frame_seq.sv
ppu_tile_fetch.sv
ppu_top.sv
ppu_asserts.sv
tb_ppu.sv
